// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
TOP       ?= joybus_tb
FILELIST  ?= tb.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== dv/joybus_sva.sv ====
`timescale 1ns/1ps

module joybus_sva (
    input logic                 sample_clk,
    input logic                 crc_reset,
    input joybus_pkg::apb_req_t apb_in,
    input joybus_pkg::apb_rsp_t apb_out,
    input logic                 joy_drive_low
);

    logic access;

    assign access = apb_in.psel && apb_in.penable;

    pready_in_access: assert property (@(posedge sample_clk) disable iff (crc_reset)
        access |-> apb_out.pready)
        else $error("pready low during an APB access phase");

    // line released right after reset
    released_after_reset: assert property (@(posedge sample_clk)
        crc_reset |=> !joy_drive_low)
        else $error("joy_drive_low active in the cycle after reset");

    pslverr_only_in_access: assert property (@(posedge sample_clk) disable iff (crc_reset)
        !access |-> !apb_out.pslverr)
        else $error("pslverr high outside an APB access phase");

endmodule

bind joybus_controller_top joybus_sva joybus_sva_inst (
    .sample_clk    (sample_clk),
    .crc_reset     (crc_reset),
    .apb_in        (apb_in),
    .apb_out       (apb_out),
    .joy_drive_low (joy_drive_low)
);

// ==== dv/joybus_tb.sv ====
`timescale 1ns/1ps

module joybus_tb;
    import joybus_pkg::*;

    localparam int rsp_wait_limit = 200;  // frame end to first pulled level
    localparam int apb_wait_limit = 4;
    localparam int max_rsp_bits = 40;
    localparam int silence_cycles = 100 * bit_width;

    logic     sample_clk;
    logic     crc_reset;
    logic     joy_rx;
    logic     joy_drive_low;
    apb_req_t apb_in;
    apb_rsp_t apb_out;

    logic [7:0] frame_bytes[$];  // console frame, command byte first
    int seed = 32'h309a;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    joybus_controller_top joybus_controller_top_inst (
        .sample_clk    (sample_clk),
        .crc_reset     (crc_reset),
        .joy_rx        (joy_rx),
        .apb_in        (apb_in),
        .apb_out       (apb_out),
        .joy_drive_low (joy_drive_low)
    );

    initial begin
        sample_clk = 1'b0;
        forever #5 sample_clk = ~sample_clk;
    end

    initial begin
        #1_000_000;
        $display("watchdog expired before the test sequence finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic step();
        @(posedge sample_clk);
        #1;  // drive point
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    // four line levels, msb first, 1 is released high
    task automatic send_levels(input logic [3:0] levels);
        int l;
        for (l = 3; l >= 0; l--) begin
            joy_rx = levels[l];
            repeat (level_width) step();
        end
    endtask

    task automatic send_frame();
        int b;
        foreach (frame_bytes[i]) begin
            for (b = 7; b >= 0; b--) begin
                send_levels(frame_bytes[i][b] ? 4'b0111 : 4'b0001);
            end
        end
        send_levels(4'b0111);  // console stop bit
        joy_rx = 1'b1;
    endtask

    // samples every cycle of a bit and checks that the next one starts 8 cycles later
    task automatic recv_response(output logic [31:0] data, output int nbits, output bit got);
        int waited;
        int k;
        logic [7:0] lv;
        bit done;
        bit bad;
        data = '0;
        nbits = 0;
        got = 1'b0;
        done = 1'b0;
        waited = 0;
        @(negedge sample_clk);
        while (!joy_drive_low && (waited < rsp_wait_limit)) begin
            @(negedge sample_clk);
            waited++;
        end
        if (!joy_drive_low) begin
            timeouts++;
            $display("no response started within %0d cycles", rsp_wait_limit);
        end else begin
            got = 1'b1;
            while (!done && (nbits < max_rsp_bits)) begin
                for (k = 0; k < bit_width; k++) begin
                    lv[7 - k] = joy_drive_low;
                    @(negedge sample_clk);
                end
                bad = 1'b0;
                case (lv)
                    8'b11111100: begin
                        data = {data[30:0], 1'b0};
                        nbits++;
                    end
                    8'b11000000: begin
                        data = {data[30:0], 1'b1};
                        nbits++;
                    end
                    8'b11110000: done = 1'b1;  // stop bit
                    default: begin
                        bad = 1'b1;
                        done = 1'b1;
                    end
                endcase
                checks++;
                assert (!bad) else begin
                    errors++;
                    $display("response bit %0d has a malformed level pattern %b", nbits, lv);
                end
                checks++;
                if (!done) begin
                    assert (joy_drive_low) else begin
                        errors++;
                        $display("response bit %0d did not last exactly 8 cycles", nbits - 1);
                        done = 1'b1;
                    end
                end else begin
                    assert (!joy_drive_low) else begin
                        errors++;
                        $display("line not released after the response stop bit");
                    end
                end
            end
            if (!done) begin
                timeouts++;
                $display("no stop bit seen after %0d response bits", max_rsp_bits);
            end
        end
        step();
    endtask

    task automatic check_no_response(input string test);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; (n < silence_cycles) && !seen; n++) begin
            @(negedge sample_clk);
            seen = joy_drive_low;
        end
        checks++;
        assert (!seen) else begin
            errors++;
            $display("%s: the controller answered a frame that needs no answer", test);
        end
        step();
    endtask

    // a frame that must get no answer and must leave LAST_CMD alone
    task automatic send_ignored_frame(input string test, input logic [7:0] kept_cmd);
        logic [31:0] rdata;
        logic        err;
        send_frame();
        check_no_response(test);
        apb_read(apb_addr_last_cmd, rdata, err);
        check_value({test, " LAST_CMD"}, {24'h0, kept_cmd}, rdata);
    endtask

    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        apb_in.psel = 1'b1;
        apb_in.penable = 1'b0;
        apb_in.pwrite = write;
        apb_in.paddr = addr;
        apb_in.pwdata = wdata;
        step();
        apb_in.penable = 1'b1;  // access phase
        waited = 0;
        @(negedge sample_clk);
        while (!apb_out.pready && (waited < apb_wait_limit)) begin
            @(negedge sample_clk);
            waited++;
        end
        if (!apb_out.pready) begin
            timeouts++;
            $display("APB transfer to offset %h never completed", addr);
        end
        rdata = apb_out.prdata;
        err = apb_out.pslverr;
        step();
        apb_in = '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, wdata, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
    endtask

    // bytewise direct form gives the remainder of the message times x^8
    function automatic logic [7:0] crc8_model(input logic [7:0] data_bytes [32]);
        logic [7:0] crc;
        int         i;
        int         b;
        crc = 8'h00;
        for (i = 0; i < 32; i++) begin
            crc = crc ^ data_bytes[i];
            for (b = 0; b < 8; b++) begin
                if (crc[7]) begin
                    crc = {crc[6:0], 1'b0} ^ 8'h85;
                end else begin
                    crc = {crc[6:0], 1'b0};
                end
            end
        end
        return crc;
    endfunction

    task automatic test_reset_values();
        logic [31:0] rdata;
        logic        err;
        apb_read(apb_addr_status, rdata, err);
        check_value("reset STATUS", 32'h0, rdata);
        check_value("reset STATUS pslverr", 32'h0, {31'b0, err});
        apb_read(apb_addr_last_cmd, rdata, err);
        check_value("reset LAST_CMD", 32'h0, rdata);
        check_value("reset LAST_CMD pslverr", 32'h0, {31'b0, err});
        apb_read(4'h8, rdata, err);
        check_value("unmapped read pslverr", 32'h1, {31'b0, err});
        apb_write(apb_addr_last_cmd, 32'h0000_00a5, err);
        check_value("LAST_CMD write pslverr", 32'h1, {31'b0, err});
        apb_read(apb_addr_last_cmd, rdata, err);
        check_value("LAST_CMD after write", 32'h0, rdata);  // read-only
    endtask

    task automatic test_info();
        logic [7:0]  cmds [2];
        logic [31:0] rsp;
        logic [31:0] rdata;
        logic        err;
        int          nbits;
        bit          got;
        cmds[0] = 8'hff;  // differs from the reset value of LAST_CMD
        cmds[1] = 8'h00;
        foreach (cmds[i]) begin
            frame_bytes.delete();
            frame_bytes.push_back(cmds[i]);
            send_frame();
            recv_response(rsp, nbits, got);
            if (got) begin
                check_value("INFO length", 32'd24, nbits);
                check_value("INFO answer", 32'h0005_0000, rsp);
            end
            apb_read(apb_addr_last_cmd, rdata, err);
            check_value("INFO LAST_CMD", {24'h0, cmds[i]}, rdata);
            wait_cycles(16);
        end
    endtask

    task automatic test_status();
        logic [31:0] values [4];
        logic [31:0] rsp;
        logic [31:0] rdata;
        logic        err;
        int          nbits;
        bit          got;
        values[0] = 32'h8000_0001;
        values[1] = 32'h1234_abcd;
        values[2] = 32'hffff_0000;
        values[3] = 32'h0f0f_3c5a;
        foreach (values[i]) begin
            apb_write(apb_addr_status, values[i], err);
            check_value("STATUS write pslverr", 32'h0, {31'b0, err});
            frame_bytes.delete();
            frame_bytes.push_back(8'h01);
            send_frame();
            recv_response(rsp, nbits, got);
            if (got) begin
                check_value("STATUS length", 32'd32, nbits);
                check_value("STATUS answer", values[i], rsp);
            end
            wait_cycles(16);
        end
        apb_read(apb_addr_last_cmd, rdata, err);
        check_value("STATUS LAST_CMD", 32'h01, rdata);
    endtask

    task automatic test_write_crc();
        logic [7:0]  data_bytes [32];
        logic [31:0] rsp;
        logic [31:0] rdata;
        logic        err;
        int          nbits;
        bit          got;
        int          n;
        int          i;
        for (n = 0; n < 2; n++) begin
            frame_bytes.delete();
            frame_bytes.push_back(8'h03);
            frame_bytes.push_back(8'($random(seed)));  // address bytes
            frame_bytes.push_back(8'($random(seed)));
            for (i = 0; i < 32; i++) begin
                data_bytes[i] = 8'($random(seed));
                frame_bytes.push_back(data_bytes[i]);
            end
            send_frame();
            recv_response(rsp, nbits, got);
            if (got) begin
                check_value("WRITE length", 32'd8, nbits);
                check_value("WRITE crc", {24'h0, crc8_model(data_bytes)}, rsp);
            end
            wait_cycles(16);
        end
        apb_read(apb_addr_last_cmd, rdata, err);
        check_value("WRITE LAST_CMD", 32'h03, rdata);
    endtask

    task automatic test_bad_frames(input logic [7:0] kept_cmd);
        int i;
        frame_bytes.delete();
        frame_bytes.push_back(8'h02);  // READ is not supported
        frame_bytes.push_back(8'h00);
        frame_bytes.push_back(8'h20);
        send_ignored_frame("command 0x02", kept_cmd);
        frame_bytes.delete();
        frame_bytes.push_back(8'h55);
        send_ignored_frame("command 0x55", kept_cmd);
        frame_bytes.delete();
        frame_bytes.push_back(8'h01);
        frame_bytes.push_back(8'h00);
        send_ignored_frame("STATUS with an extra byte", kept_cmd);
        frame_bytes.delete();
        frame_bytes.push_back(8'h03);
        for (i = 0; i < 33; i++) begin
            frame_bytes.push_back(8'($random(seed)));
        end
        send_ignored_frame("WRITE one byte short", kept_cmd);
    endtask

    initial begin
        crc_reset = 1'b1;
        joy_rx = 1'b1;  // idle line
        apb_in = '0;
        repeat (16) @(posedge sample_clk);
        #1;
        crc_reset = 1'b0;
        wait_cycles(4);
        test_reset_values();
        test_info();
        test_bad_frames(8'h00);  // last answered command was INFO 0x00
        test_status();
        test_write_crc();
        wait_cycles(10);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/joybus_apb_regs.sv ====
`timescale 1ns/1ps

module joybus_apb_regs (
    input  logic                 sample_clk,
    input  logic                 crc_reset,
    input  joybus_pkg::apb_req_t apb_in,
    output joybus_pkg::apb_rsp_t apb_out,
    input  logic [7:0]           last_cmd,
    input  logic                 cmd_seen,
    output logic [31:0]          status_word
);
    import joybus_pkg::*;

    logic       access;
    logic       sel_status;
    logic       sel_last;
    logic [7:0] last_cmd_reg;

    assign access = apb_in.psel && apb_in.penable;
    assign sel_status = (apb_in.paddr == apb_addr_status);
    assign sel_last = (apb_in.paddr == apb_addr_last_cmd);

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            status_word <= '0;
            last_cmd_reg <= '0;
        end else begin
            if (access && apb_in.pwrite && sel_status) begin
                status_word <= apb_in.pwdata;
            end
            if (cmd_seen) begin
                last_cmd_reg <= last_cmd;  // only answered frames
            end
        end
    end

    always_comb begin
        apb_out.pready = 1'b1;  // zero wait states
        apb_out.pslverr = access && (!(sel_status || sel_last) || (apb_in.pwrite && sel_last));
        apb_out.prdata = '0;
        if (sel_status) begin
            apb_out.prdata = status_word;
        end else if (sel_last) begin
            apb_out.prdata = {24'h000000, last_cmd_reg};
        end
    end

endmodule

// ==== hdl/joybus_controller_top.sv ====
`timescale 1ns/1ps

module joybus_controller_top (
    input  logic                 sample_clk,
    input  logic                 crc_reset,
    input  logic                 joy_rx,
    input  joybus_pkg::apb_req_t apb_in,
    output joybus_pkg::apb_rsp_t apb_out,
    output logic                 joy_drive_low
);
    import joybus_pkg::*;

    rx_byte_t    rx_byte;
    rx_bit_t     rx_bit;
    tx_req_t     tx_req;
    logic        frame_done;
    logic        rx_enable;
    logic        crc_clear;
    logic        crc_shift;
    logic        crc_data;
    logic        crc_flush;
    logic [7:0]  crc_value;
    logic        tx_busy;
    logic        tx_done;
    logic [7:0]  last_cmd;
    logic        cmd_seen;
    logic [31:0] status_word;

    joybus_rx_decoder joybus_rx_decoder_inst (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .joy_rx     (joy_rx),
        .enable     (rx_enable),
        .rx_byte    (rx_byte),
        .rx_bit     (rx_bit),
        .frame_done (frame_done)
    );

    joybus_crc8 joybus_crc8_inst (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .clear      (crc_clear),
        .shift      (crc_shift),
        .data       (crc_data),
        .flush      (crc_flush),
        .crc_value  (crc_value)
    );

    joybus_sequencer joybus_sequencer_inst (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .rx_byte     (rx_byte),
        .rx_bit      (rx_bit),
        .frame_done  (frame_done),
        .crc_value   (crc_value),
        .tx_busy     (tx_busy),
        .tx_done     (tx_done),
        .status_word (status_word),
        .crc_clear   (crc_clear),
        .crc_shift   (crc_shift),
        .crc_data    (crc_data),
        .crc_flush   (crc_flush),
        .tx_req      (tx_req),
        .rx_enable   (rx_enable),
        .last_cmd    (last_cmd),
        .cmd_seen    (cmd_seen)
    );

    joybus_tx_encoder joybus_tx_encoder_inst (
        .sample_clk    (sample_clk),
        .crc_reset     (crc_reset),
        .req           (tx_req),
        .joy_drive_low (joy_drive_low),
        .tx_busy       (tx_busy),
        .tx_done       (tx_done)
    );

    joybus_apb_regs joybus_apb_regs_inst (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .apb_in      (apb_in),
        .apb_out     (apb_out),
        .last_cmd    (last_cmd),
        .cmd_seen    (cmd_seen),
        .status_word (status_word)
    );

endmodule

// ==== hdl/joybus_crc8.sv ====
`timescale 1ns/1ps

module joybus_crc8 (
    input  logic       sample_clk,
    input  logic       crc_reset,
    input  logic       clear,
    input  logic       shift,
    input  logic       data,
    input  logic       flush,
    output logic [7:0] crc_value
);
    import joybus_pkg::*;

    logic din;

    assign din = flush ? 1'b0 : data;  // flush pushes zeros

    // augmented form, message enters at the lsb and 8 zero shifts finish it
    always_ff @(posedge sample_clk) begin
        if (crc_reset || clear) begin
            crc_value <= '0;
        end else if (shift || flush) begin
            crc_value <= {crc_value[6:0], din} ^ (crc_value[7] ? crc_poly : 8'h00);
        end
    end

endmodule

// ==== hdl/joybus_level_timer.sv ====
`timescale 1ns/1ps

module joybus_level_timer (
    input  logic       sample_clk,
    input  logic       crc_reset,
    input  logic       restart,
    input  logic       run,
    output logic [4:0] cycle,
    output logic [2:0] level_phase,
    output logic       bit_end
);
    import joybus_pkg::*;

    // saturates at all ones so the count doubles as an idle timeout
    always_ff @(posedge sample_clk) begin
        if (crc_reset || restart) begin
            cycle <= '0;
        end else if (run && (cycle != '1)) begin
            cycle <= cycle + 5'd1;
        end
    end

    assign level_phase = 3'(cycle % 5'(bit_width));      // position within current bit
    assign bit_end = (level_phase == 3'(bit_width - 1));  // last cycle of the bit

endmodule

// ==== hdl/joybus_pkg.sv ====
package joybus_pkg;

    // line timing, in sample_clk cycles
    localparam int unsigned level_width = 2;
    localparam int unsigned bit_width = 4 * level_width;
    localparam int unsigned rx_sample_phase = 4;   // second level of a bit
    localparam int unsigned rx_idle_cycles = 24;   // three bit times of high line

    // console command codes
    localparam logic [7:0] cmd_info = 8'h00;
    localparam logic [7:0] cmd_info_alt = 8'hff;
    localparam logic [7:0] cmd_status = 8'h01;
    localparam logic [7:0] cmd_write = 8'h03;

    localparam int unsigned write_frame_bytes = 35;  // cmd + 2 addr + 32 data

    localparam logic [23:0] info_response = 24'h050000;  // standard controller id
    localparam logic [7:0] crc_poly = 8'h85;

    // APB register offsets
    localparam logic [3:0] apb_addr_status = 4'h0;
    localparam logic [3:0] apb_addr_last_cmd = 4'h4;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic [5:0] index;  // byte position within frame
    } rx_byte_t;

    typedef struct packed {
        logic valid;
        logic value;
    } rx_bit_t;

    typedef struct packed {
        logic        start;
        logic [31:0] payload;  // left aligned, msb goes first
        logic [5:0]  len;      // bits to send
    } tx_req_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

// ==== hdl/joybus_rx_decoder.sv ====
`timescale 1ns/1ps

module joybus_rx_decoder (
    input  logic                 sample_clk,
    input  logic                 crc_reset,
    input  logic                 joy_rx,
    input  logic                 enable,
    output joybus_pkg::rx_byte_t rx_byte,
    output joybus_pkg::rx_bit_t  rx_bit,
    output logic                 frame_done
);
    import joybus_pkg::*;

    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       in_frame;
    logic       fall;
    logic       sample;
    logic [2:0] bit_cnt;
    logic [6:0] shreg;
    logic [5:0] byte_idx;
    logic [4:0] cycle;

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            rx_meta <= 1'b1;  // idle line is high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= joy_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = enable && rx_prev && !rx_sync;
    assign sample = in_frame && (cycle == 5'(rx_sample_phase - 1));
    assign frame_done = in_frame && (cycle == 5'(rx_idle_cycles - 1));

    joybus_level_timer joybus_level_timer_inst (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .restart     (fall),
        .run         (in_frame),
        .cycle       (cycle),
        .level_phase (),
        .bit_end     ()
    );

    always_ff @(posedge sample_clk) begin
        if (crc_reset || frame_done || !enable) begin
            in_frame <= 1'b0;  // partial byte is dropped here
            bit_cnt <= '0;
            byte_idx <= '0;
        end else begin
            if (fall) begin
                in_frame <= 1'b1;
            end
            if (sample) begin
                bit_cnt <= bit_cnt + 3'd1;
                if ((bit_cnt == 3'd7) && (byte_idx != '1)) begin
                    byte_idx <= byte_idx + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (sample) begin
            shreg <= {shreg[5:0], rx_sync};  // msb first
        end
    end

    assign rx_byte.valid = sample && (bit_cnt == 3'd7);
    assign rx_byte.data = {shreg, rx_sync};
    assign rx_byte.index = byte_idx;
    assign rx_bit.valid = sample;
    assign rx_bit.value = rx_sync;

endmodule

// ==== hdl/joybus_sequencer.sv ====
`timescale 1ns/1ps

module joybus_sequencer (
    input  logic                 sample_clk,
    input  logic                 crc_reset,
    input  joybus_pkg::rx_byte_t rx_byte,
    input  joybus_pkg::rx_bit_t  rx_bit,
    input  logic                 frame_done,
    input  logic [7:0]           crc_value,
    input  logic                 tx_busy,
    input  logic                 tx_done,
    input  logic [31:0]          status_word,
    output logic                 crc_clear,
    output logic                 crc_shift,
    output logic                 crc_data,
    output logic                 crc_flush,
    output joybus_pkg::tx_req_t  tx_req,
    output logic                 rx_enable,
    output logic [7:0]           last_cmd,
    output logic                 cmd_seen
);
    import joybus_pkg::*;

    typedef enum logic [1:0] {st_idle, st_receiving, st_flushing, st_sending} state_t;

    state_t     state;
    logic [7:0] cmd;
    logic [6:0] byte_count;
    logic [2:0] flush_cnt;
    logic       kick;
    logic       short_cmd;
    logic       long_cmd;
    logic       fits;

    assign short_cmd = (cmd == cmd_info) || (cmd == cmd_info_alt) || (cmd == cmd_status);
    assign long_cmd = (cmd == cmd_write);
    assign fits = (short_cmd && (byte_count == 7'd1))
                  || (long_cmd && (byte_count == 7'(write_frame_bytes)));

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            state <= st_idle;
            byte_count <= '0;
            flush_cnt <= '0;
            kick <= 1'b0;
            last_cmd <= '0;
            cmd_seen <= 1'b0;
        end else begin
            kick <= 1'b0;
            cmd_seen <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_byte.valid && (rx_byte.index == '0)) begin
                        byte_count <= 7'd1;
                        state <= st_receiving;
                    end
                end
                st_receiving: begin
                    if (rx_byte.valid) begin
                        byte_count <= {1'b0, rx_byte.index} + 7'd1;
                    end
                    if (frame_done) begin
                        if (fits) begin
                            last_cmd <= cmd;
                            cmd_seen <= 1'b1;
                            flush_cnt <= '0;
                            kick <= !long_cmd;  // short answers go out next cycle
                            state <= long_cmd ? st_flushing : st_sending;
                        end else begin
                            state <= st_idle;  // no answer
                        end
                    end
                end
                st_flushing: begin
                    flush_cnt <= flush_cnt + 3'd1;
                    if (flush_cnt == 3'd7) begin
                        kick <= 1'b1;  // crc settles on the same edge
                        state <= st_sending;
                    end
                end
                default: begin
                    if (tx_done) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sample_clk) begin
        if ((state == st_idle) && rx_byte.valid) begin
            cmd <= rx_byte.data;
        end
    end

    // data bytes of a write are bytes 3 to 34, console stop bit excluded
    assign crc_shift = (state == st_receiving) && long_cmd && rx_bit.valid
                       && (byte_count >= 7'd3) && (byte_count < 7'(write_frame_bytes));
    assign crc_data = rx_bit.value;
    assign crc_clear = (state == st_idle);
    assign crc_flush = (state == st_flushing);
    assign rx_enable = !tx_busy && ((state == st_idle) || (state == st_receiving));

    always_comb begin
        tx_req.start = kick;
        if (long_cmd) begin
            tx_req.payload = {crc_value, 24'h000000};
            tx_req.len = 6'($bits(crc_value));
        end else if (cmd == cmd_status) begin
            tx_req.payload = status_word;  // raw button and stick word
            tx_req.len = 6'($bits(status_word));
        end else begin
            tx_req.payload = {info_response, 8'h00};
            tx_req.len = 6'($bits(info_response));
        end
    end

endmodule

// ==== hdl/joybus_tx_encoder.sv ====
`timescale 1ns/1ps

module joybus_tx_encoder (
    input  logic                sample_clk,
    input  logic                crc_reset,
    input  joybus_pkg::tx_req_t req,
    output logic                joy_drive_low,
    output logic                tx_busy,
    output logic                tx_done
);
    import joybus_pkg::*;

    logic [31:0]          shreg;
    logic [5:0]           bits_left;
    logic                 in_stop;
    logic                 load;
    logic [2:0]           level_phase;
    logic                 bit_end;
    logic [bit_width-1:0] pattern;

    // one bit as its sequence of line levels, 0 means pulled low
    function automatic logic [bit_width-1:0] level_pattern(input logic stop, input logic value);
        logic [level_width-1:0] lo;
        logic [level_width-1:0] hi;
        lo = '0;
        hi = '1;
        if (stop) begin
            return {lo, lo, hi, hi};  // last level is release
        end
        return value ? {lo, hi, hi, hi} : {lo, lo, lo, hi};
    endfunction

    assign load = req.start && !tx_busy;

    joybus_level_timer joybus_level_timer_inst (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .restart     (load || (tx_busy && bit_end)),
        .run         (tx_busy),
        .cycle       (),
        .level_phase (level_phase),
        .bit_end     (bit_end)
    );

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
            in_stop <= 1'b0;
            bits_left <= '0;
        end else begin
            tx_done <= 1'b0;
            if (load) begin
                tx_busy <= 1'b1;
                in_stop <= (req.len == '0);
                bits_left <= req.len;
            end else if (tx_busy && bit_end) begin
                if (in_stop) begin
                    tx_busy <= 1'b0;  // line released
                    tx_done <= 1'b1;
                    in_stop <= 1'b0;
                end else begin
                    bits_left <= bits_left - 6'd1;
                    in_stop <= (bits_left == 6'd1);
                end
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (load) begin
            shreg <= req.payload;
        end else if (tx_busy && bit_end && !in_stop) begin
            shreg <= {shreg[30:0], 1'b0};
        end
    end

    assign pattern = level_pattern(in_stop, shreg[31]);
    assign joy_drive_low = tx_busy && !pattern[3'(bit_width - 1) - level_phase];

endmodule

// ==== tb.f ====
hdl/joybus_pkg.sv
hdl/joybus_level_timer.sv
hdl/joybus_rx_decoder.sv
hdl/joybus_crc8.sv
hdl/joybus_tx_encoder.sv
hdl/joybus_sequencer.sv
hdl/joybus_apb_regs.sv
hdl/joybus_controller_top.sv
dv/joybus_sva.sv
dv/joybus_tb.sv
